/* verilog.f */
logic/rv_mem_pkg.sv
logic/data_memory.sv
logic/mem_arbiter.sv
logic/dma_copier.sv
logic/data_mem_subsystem.sv
verif/tb_data_mem_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the data memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f \
  --top-module tb_data_mem_subsystem -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "Testbench reported failure, see sim.log"
  exit 1
fi
echo "Run clean"

/* verif/mem_input.txt */
# op  addr/src  data/dst  size/len  expected, all hex after the op letter
# W store, R load, D DMA copy, X DMA copy under core loads; expected used by R only
W 00000000 12345678 2 00000000
R 00000000 00000000 2 12345678
R 00000200 00000000 2 00000000
W 00000010 aabbccdd 2 00000000
W 00000011 000000ee 0 00000000
W 00000014 11223344 2 00000000
W 00000017 0000beef 1 00000000
R 00000010 00000000 2 aabbeedd
R 00000014 00000000 2 beef3344
W 00000020 80ff7f01 2 00000000
R 00000023 00000000 0 ffffff80
R 00000023 00000000 4 00000080
R 00000021 00000000 0 0000007f
R 00000022 00000000 1 ffff80ff
R 00000022 00000000 5 000080ff
R 00000023 00000000 1 ffff80ff
R 00000022 00000000 2 80ff7f01
W 00001030 cafef00d 2 00000000
R 00000030 00000000 2 cafef00d
W 00000020 deadbeef 3 00000000
R 00000020 00000000 2 80ff7f01
R 00000020 00000000 3 00000000
W 00000100 11111111 2 00000000
W 00000104 22222222 2 00000000
W 00000108 33333333 2 00000000
W 0000010c 44444444 2 00000000
D 00000100 00000200 04 00000000
R 00000200 00000000 2 11111111
R 00000204 00000000 2 22222222
R 00000208 00000000 2 33333333
R 0000020c 00000000 2 44444444
X 00000100 00000300 04 00000000
R 00000300 00000000 2 11111111
R 0000030c 00000000 2 44444444
X 00000010 00000400 05 00000000
R 00000404 00000000 2 beef3344
R 00000410 00000000 2 80ff7f01

/* verif/tb_data_mem_subsystem.sv */
/*
  Testbench for the data memory subsystem
  Replays core stores, loads and DMA copies from a vector file
  Loads checked against file values and a byte shadow of the memory
*/
`timescale 1ns/10ps

module tb_data_mem_subsystem import rv_mem_pkg::*; ();

  localparam int unsigned MEM_SIZE = 4096;
  localparam int IDX_W     = $clog2(MEM_SIZE);
  localparam int GNT_WAIT  = 20;   // Cycles allowed for one grant
  localparam int DONE_WAIT = 600;  // Enough for a 255 word copy

  typedef struct packed {
    logic [7:0]  op;       // W, R, D or X
    logic [31:0] addr;     // Address or DMA source
    logic [31:0] data;     // Store data or DMA destination
    logic [7:0]  size;     // funct3 code or DMA length
    logic [31:0] exp_val;  // Expected load result
  } vector_t;

  logic        clk;
  logic        reset;
  mem_req_t    core_req;
  logic        core_gnt;
  logic [31:0] core_rdata;
  logic        dma_start;
  logic [31:0] dma_src;
  logic [31:0] dma_dst;
  logic [7:0]  dma_len;
  logic        dma_busy;
  logic        dma_done;

  vector_t    vectors[$];
  logic [7:0] shadow [MEM_SIZE];  // Expected memory contents
  int         errors = 0;
  int         monitor_errors = 0;
  int         checks = 0;
  int         done_count = 0;     // dma_done pulses seen
  int         cycle_count = 0;
  int         cycle_limit = 600;

  data_mem_subsystem #(.MEM_SIZE(MEM_SIZE)) i_data_mem_subsystem (
    .clk        (clk),
    .reset      (reset),
    .core_req   (core_req),
    .core_gnt   (core_gnt),
    .core_rdata (core_rdata),
    .dma_start  (dma_start),
    .dma_src    (dma_src),
    .dma_dst    (dma_dst),
    .dma_len    (dma_len),
    .dma_busy   (dma_busy),
    .dma_done   (dma_done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // Watchdog with its limit set once the vectors are loaded
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, run stopped", cycle_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Counts done pulses and expects busy already low
  always @(negedge clk) begin
    if (dma_done) begin
      done_count = done_count + 1;
      if (dma_busy !== 1'b0) begin
        $display("FAIL t=%0t dma_busy expected 0 got %b", $time, dma_busy);
        monitor_errors = monitor_errors + 1;
      end
    end
  end

  function automatic logic [IDX_W-1:0] byte_index(input logic [31:0] addr);
    return IDX_W'(addr % MEM_SIZE);  // Wrap into the memory
  endfunction

  // Little endian word from the shadow with bits 1:0 ignored
  function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    logic [IDX_W-1:0] base;
    base = byte_index({addr[31:2], 2'b00});
    return {shadow[base + IDX_W'(3)], shadow[base + IDX_W'(2)],
            shadow[base + IDX_W'(1)], shadow[base]};
  endfunction

  task automatic shadow_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [2:0] size);
    logic [IDX_W-1:0] base;
    case (size)
      3'b000: shadow[byte_index(addr)] = data[7:0];
      3'b001: begin
        base = byte_index({addr[31:1], 1'b0});  // Bit 0 dropped
        shadow[base]              = data[7:0];
        shadow[base + IDX_W'(1)] = data[15:8];
      end
      3'b010: begin
        base = byte_index({addr[31:2], 2'b00});
        for (int k = 0; k < 4; k++) shadow[base + IDX_W'(k)] = data[8*k +: 8];
      end
      default: ;  // Unknown code stores nothing
    endcase
  endtask

  task automatic compare_word(input string name, input logic [31:0] exp_val,
                              input logic [31:0] got);
    checks = checks + 1;
    if (got !== exp_val) begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp_val, got);
      errors = errors + 1;
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic core_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [2:0] size, input logic write,
                             output logic [31:0] rdata, output logic granted);
    int waited;
    waited  = 0;
    granted = 1'b0;
    rdata   = 32'h0;
    core_req.addr  = addr;
    core_req.wdata = wdata;
    core_req.size  = size;
    core_req.rd    = ~write;
    core_req.wr    = write;
    while (!granted && waited < GNT_WAIT) begin
      @(negedge clk);  // Grant and load data settled here
      if (core_gnt) begin
        granted = 1'b1;
        rdata   = core_rdata;
      end else begin
        compare_word("core_rdata", 32'h0, core_rdata);  // Zero while the DMA owns the memory
      end
      waited = waited + 1;
    end
    @(posedge clk);  // Store commits on this edge
    #1;
    core_req = '0;
    if (!granted) begin
      $display("No grant for core access at %h within %0d cycles", addr, GNT_WAIT);
      errors = errors + 1;
    end
  endtask

  // DMA copy with optional random core loads of the source block
  task automatic run_copy(input logic [31:0] src, input logic [31:0] dst,
                          input logic [7:0] len, input logic with_loads);
    int start_count;
    int waited;
    int loads;
    logic [31:0] addr;
    logic [31:0] got;
    logic granted;
    start_count = done_count;
    waited = 0;
    loads  = 0;
    dma_src   = src;
    dma_dst   = dst;
    dma_len   = len;
    dma_start = 1'b1;
    @(posedge clk);
    #1;
    dma_start = 1'b0;
    if (dma_busy !== 1'b1) begin
      $display("DMA did not turn busy after start, src %h", src);
      errors = errors + 1;
    end
    while (with_loads && done_count == start_count && loads < 64) begin
      addr = src + 32'(4 * ($urandom % 32'(len)));
      core_access(addr, 32'h0, 3'b010, 1'b0, got, granted);  // LW
      if (granted) compare_word("core_rdata", shadow_word(addr), got);
      loads = loads + 1;
    end
    while (done_count == start_count && waited < DONE_WAIT) begin
      @(posedge clk);
      #1;
      waited = waited + 1;
    end
    if (done_count == start_count) begin
      $display("DMA copy from %h to %h never signalled done", src, dst);
      errors = errors + 1;
    end
    for (int k = 0; k < 32'(len); k++) begin  // Word order as in the engine
      shadow_store(dst + 32'(4 * k), shadow_word(src + 32'(4 * k)), 3'b010);
    end
  endtask

  initial begin
    int fd;
    int n;
    string op;
    string rest;
    vector_t v;
    logic [31:0] a;
    logic [31:0] b;
    logic [7:0] c;
    logic [31:0] e;
    logic [31:0] got;
    logic granted;
    void'($urandom(32'ha2f3a1f1));
    reset     = 1'b1;
    core_req  = '0;
    dma_start = 1'b0;
    dma_src   = 32'h0;
    dma_dst   = 32'h0;
    dma_len   = 8'h0;
    foreach (shadow[i]) shadow[i] = 8'h00;  // Memory starts cleared

    fd = $fopen("verif/mem_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verif/mem_input.txt, no vectors run");
      errors = errors + 1;
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", op);
        if (n != 1) break;
        if (op == "#") begin
          n = $fgets(rest, fd);  // Column notes
        end else begin
          n = $fscanf(fd, "%h %h %h %h", a, b, c, e);
          if (n != 4) begin
            $display("Malformed vector line starting with %s", op);
            errors = errors + 1;
            break;
          end
          v = '{op: op.getc(0), addr: a, data: b, size: c, exp_val: e};
          vectors.push_back(v);
        end
      end
      $fclose(fd);
    end
    cycle_limit = 40 * vectors.size() + 600;

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    if (core_gnt !== 1'b0 || dma_busy !== 1'b0 || dma_done !== 1'b0) begin
      $display("Grant, busy or done not low after reset");
      errors = errors + 1;
    end

    foreach (vectors[i]) begin
      v = vectors[i];
      case (v.op)
        "W": begin
          core_access(v.addr, v.data, v.size[2:0], 1'b1, got, granted);
          if (granted) shadow_store(v.addr, v.data, v.size[2:0]);
        end
        "R": begin
          core_access(v.addr, 32'h0, v.size[2:0], 1'b0, got, granted);
          if (granted) compare_word("core_rdata", v.exp_val, got);
        end
        "D": run_copy(v.addr, v.data, v.size, 1'b0);
        "X": run_copy(v.addr, v.data, v.size, 1'b1);  // Contended copy
        default: begin
          $display("Unknown op code %h in vector %0d", v.op, i);
          errors = errors + 1;
        end
      endcase
    end

    repeat (2) @(posedge clk);
    $display("Checks: %0d  errors: %0d", checks, errors + monitor_errors);
    if (errors + monitor_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* logic/data_mem_subsystem.sv */
/*
  Data memory subsystem
  Core port and word copy DMA share one byte memory through a round-robin arbiter
*/
`timescale 1ns/10ps

module data_mem_subsystem import rv_mem_pkg::*; #(
  parameter int unsigned MEM_SIZE = 4096  // Bytes
) (
  input  logic        clk,
  input  logic        reset,
  input  mem_req_t    core_req,    // Held until granted
  output logic        core_gnt,
  output logic [31:0] core_rdata,  // Valid in granted cycle
  input  logic        dma_start,   // One cycle command
  input  logic [31:0] dma_src,
  input  logic [31:0] dma_dst,
  input  logic [7:0]  dma_len,     // Words
  output logic        dma_busy,
  output logic        dma_done
);

  mem_req_t    mem_req;    // Winner's request
  mem_req_t    dma_req;
  logic [31:0] mem_rdata;
  logic [31:0] dma_rdata;
  logic        dma_gnt;

  mem_arbiter i_mem_arbiter (
    .clk        (clk),
    .reset      (reset),
    .core_req   (core_req),
    .dma_req    (dma_req),
    .mem_rdata  (mem_rdata),
    .mem_req    (mem_req),
    .core_gnt   (core_gnt),
    .dma_gnt    (dma_gnt),
    .core_rdata (core_rdata),
    .dma_rdata  (dma_rdata)
  );

  data_memory #(
    .MEM_SIZE (MEM_SIZE)
  ) i_data_memory (
    .clk       (clk),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata)
  );

  dma_copier #(
    .MEM_SIZE (MEM_SIZE)
  ) i_dma_copier (
    .clk       (clk),
    .reset     (reset),
    .dma_start (dma_start),
    .dma_src   (dma_src),
    .dma_dst   (dma_dst),
    .dma_len   (dma_len),
    .dma_req   (dma_req),
    .dma_gnt   (dma_gnt),
    .dma_rdata (dma_rdata),
    .dma_busy  (dma_busy),
    .dma_done  (dma_done)
  );

endmodule

/* logic/dma_copier.sv */
/*
  Word copy DMA engine
  Reads word k from src+4k into a holding register, writes it to dst+4k
  One granted read and one granted write per word, done pulse at the end
*/
`timescale 1ns/10ps

module dma_copier import rv_mem_pkg::*; #(
  parameter int unsigned MEM_SIZE = 4096
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        dma_start,
  input  logic [31:0] dma_src,
  input  logic [31:0] dma_dst,
  input  logic [7:0]  dma_len,
  output mem_req_t    dma_req,
  input  logic        dma_gnt,
  input  logic [31:0] dma_rdata,
  output logic        dma_busy,
  output logic        dma_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } dma_state_t;

  dma_state_t        state;
  logic [7:0]        words_left;  // Words still to write
  logic [ADDR_W-1:0] src_addr;
  logic [ADDR_W-1:0] dst_addr;
  logic [31:0]       data_hold;   // Word between read and write
  logic              start_ok;

  // Command only taken while idle
  assign start_ok = dma_start && (state == ST_IDLE);
  assign dma_busy = (state != ST_IDLE);

  // Control FSM, advances on granted edges only
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_IDLE;
      words_left <= 8'd0;
      dma_done   <= 1'b0;
    end else begin
      dma_done <= 1'b0;  // Single cycle pulse
      case (state)
        ST_IDLE: begin
          if (start_ok) begin
            if (dma_len == 8'd0) begin
              dma_done <= 1'b1;  // Nothing to copy
            end else begin
              words_left <= dma_len;
              state      <= ST_READ;
            end
          end
        end
        ST_READ: begin
          if (dma_gnt) state <= ST_WRITE;
        end
        ST_WRITE: begin
          if (dma_gnt) begin
            words_left <= words_left - 8'd1;
            if (words_left == 8'd1) begin
              state    <= ST_IDLE;
              dma_done <= 1'b1;  // Last word committed
            end else begin
              state <= ST_READ;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Running addresses and data, wrapped to the memory size
  always_ff @(posedge clk) begin
    if (start_ok) begin
      src_addr <= dma_src % ADDR_W'(MEM_SIZE);
      dst_addr <= dma_dst % ADDR_W'(MEM_SIZE);
    end
    if (state == ST_READ && dma_gnt) begin
      data_hold <= dma_rdata;
      src_addr  <= (src_addr + ADDR_W'(4)) % ADDR_W'(MEM_SIZE);
    end
    if (state == ST_WRITE && dma_gnt) begin
      dst_addr <= (dst_addr + ADDR_W'(4)) % ADDR_W'(MEM_SIZE);
    end
  end

  // LW in read state, SW in write state
  always_comb begin
    dma_req = MEM_REQ_IDLE;
    case (state)
      ST_READ: begin
        dma_req.addr = src_addr;
        dma_req.size = SIZE_W;
        dma_req.rd   = 1'b1;
      end
      ST_WRITE: begin
        dma_req.addr  = dst_addr;
        dma_req.wdata = data_hold;
        dma_req.size  = SIZE_W;
        dma_req.wr    = 1'b1;
      end
      default: dma_req = MEM_REQ_IDLE;
    endcase
  end

endmodule

/* logic/mem_arbiter.sv */
/*
  Round-robin arbiter for the data memory
  Core load/store port against the DMA port, read data to the winner only
*/
`timescale 1ns/10ps

module mem_arbiter import rv_mem_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  mem_req_t    core_req,
  input  mem_req_t    dma_req,
  input  logic [31:0] mem_rdata,
  output mem_req_t    mem_req,
  output logic        core_gnt,
  output logic        dma_gnt,
  output logic [31:0] core_rdata,
  output logic [31:0] dma_rdata
);

  logic core_act;
  logic dma_act;
  logic last_was_dma;  // Peer granted most recently

  // A peer asks when either level is up
  assign core_act = core_req.rd | core_req.wr;
  assign dma_act  = dma_req.rd | dma_req.wr;

  // Lone requester wins at once
  // On contention the peer that lost last time goes
  assign core_gnt = core_act & (~dma_act | last_was_dma);
  assign dma_gnt  = dma_act & (~core_act | ~last_was_dma);

  always_ff @(posedge clk) begin
    if (reset) begin
      last_was_dma <= 1'b1;  // Core wins the first tie
    end else if (core_gnt) begin
      last_was_dma <= 1'b0;
    end else if (dma_gnt) begin
      last_was_dma <= 1'b1;
    end
  end

  // Request mux toward the memory
  always_comb begin
    if (core_gnt) begin
      mem_req = core_req;
    end else if (dma_gnt) begin
      mem_req = dma_req;
    end else begin
      mem_req = MEM_REQ_IDLE;  // Nobody asking
    end
  end

  // Loser sees zero
  assign core_rdata = core_gnt ? mem_rdata : 32'h0;
  assign dma_rdata  = dma_gnt ? mem_rdata : 32'h0;

endmodule

/* logic/data_memory.sv */
/*
  Data memory, byte addressable
  Byte, halfword and word stores with lane steering
  Combinational loads with sign or zero extension
*/
`timescale 1ns/10ps

module data_memory import rv_mem_pkg::*; #(
  parameter int unsigned MEM_SIZE = 4096  // Bytes, multiple of 4
) (
  input  logic        clk,
  input  mem_req_t    mem_req,
  output logic [31:0] mem_rdata
);

  localparam int IDX_W = $clog2(MEM_SIZE);

  // Storage, zero at start
  logic [7:0] mem [MEM_SIZE] = '{default: 8'h00};

  // Wrapped linear addresses
  logic [ADDR_W-1:0] byte_lin;
  logic [ADDR_W-1:0] half_lin;
  logic [ADDR_W-1:0] word_lin;

  logic [IDX_W-1:0] byte_idx;
  logic [IDX_W-1:0] half_idx;
  logic [IDX_W-1:0] word_idx;

  logic [7:0]  byte_data;
  logic [15:0] half_data;
  logic [31:0] word_data;

  // Halfword drops bit 0, word drops bits 1:0, then wrap
  assign byte_lin = mem_req.addr % ADDR_W'(MEM_SIZE);
  assign half_lin = {mem_req.addr[ADDR_W-1:1], 1'b0} % ADDR_W'(MEM_SIZE);
  assign word_lin = {mem_req.addr[ADDR_W-1:2], 2'b00} % ADDR_W'(MEM_SIZE);

  assign byte_idx = byte_lin[IDX_W-1:0];
  assign half_idx = half_lin[IDX_W-1:0];
  assign word_idx = word_lin[IDX_W-1:0];

  // Little endian lane assembly
  assign byte_data = mem[byte_idx];
  assign half_data = {mem[half_idx + IDX_W'(1)], mem[half_idx]};
  assign word_data = {mem[word_idx + IDX_W'(3)], mem[word_idx + IDX_W'(2)],
                      mem[word_idx + IDX_W'(1)], mem[word_idx]};

  // Store at the rising edge
  always_ff @(posedge clk) begin
    if (mem_req.wr) begin
      case (mem_req.size)
        SIZE_B: begin
          mem[byte_idx] <= mem_req.wdata[7:0];  // Low byte only
        end
        SIZE_H: begin
          mem[half_idx]              <= mem_req.wdata[7:0];
          mem[half_idx + IDX_W'(1)] <= mem_req.wdata[15:8];
        end
        SIZE_W: begin
          mem[word_idx]              <= mem_req.wdata[7:0];
          mem[word_idx + IDX_W'(1)] <= mem_req.wdata[15:8];
          mem[word_idx + IDX_W'(2)] <= mem_req.wdata[23:16];
          mem[word_idx + IDX_W'(3)] <= mem_req.wdata[31:24];
        end
        default: begin
          // Unknown code, memory untouched
        end
      endcase
    end
  end

  // Load path, zero unless rd
  always_comb begin
    mem_rdata = 32'h0;
    if (mem_req.rd) begin
      case (mem_req.size)
        SIZE_B:  mem_rdata = {{24{byte_data[7]}}, byte_data};   // Sign extend
        SIZE_H:  mem_rdata = {{16{half_data[15]}}, half_data};
        SIZE_W:  mem_rdata = word_data;
        SIZE_BU: mem_rdata = {24'h0, byte_data};                // Zero extend
        SIZE_HU: mem_rdata = {16'h0, half_data};
        default: mem_rdata = 32'h0;
      endcase
    end
  end

endmodule

/* logic/rv_mem_pkg.sv */
/*
  RV32I data memory shared definitions
  Load/store size coding after funct3, request struct and address width
*/
package rv_mem_pkg;

  // Byte address width of every requester
  localparam int ADDR_W = 32;

  // funct3 of the load/store instruction
  typedef logic [2:0] mem_size_t;

  localparam mem_size_t SIZE_B  = 3'b000;  // LB / SB
  localparam mem_size_t SIZE_H  = 3'b001;  // LH / SH
  localparam mem_size_t SIZE_W  = 3'b010;  // LW / SW
  localparam mem_size_t SIZE_BU = 3'b100;  // LBU, load only
  localparam mem_size_t SIZE_HU = 3'b101;  // LHU, load only

  // Any other code reads zero and stores nothing

  // One memory access, 69 bits
  // rd and wr are levels, both low means idle
  typedef struct packed {
    logic [ADDR_W-1:0] addr;   // Byte address
    logic [31:0]       wdata;  // Store data, low lanes used for SB/SH
    mem_size_t         size;   // Access size and sign
    logic              rd;     // Load request
    logic              wr;     // Store request
  } mem_req_t;

  // Idle request driven when nobody owns the memory
  localparam mem_req_t MEM_REQ_IDLE = '{
    addr:  '0,
    wdata: '0,
    size:  SIZE_B,
    rd:    1'b0,
    wr:    1'b0
  };

endpackage
